// File: hw/periph_pkg.sv
////////////////////
// Peripheral subsystem package
// Address map, register offsets, widths and interrupt IDs
////////////////////

package periph_pkg;

  // Bus words
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Region field is addr[15:12]
  typedef logic [3:0] region_t;
  localparam region_t REGION_INTR  = 4'h0;
  localparam region_t REGION_GPIO  = 4'h1;
  localparam region_t REGION_TIMER = 4'h2;

  // Register offset is addr[3:0]
  typedef logic [3:0] offset_t;
  localparam offset_t OFS_0 = 4'h0;
  localparam offset_t OFS_4 = 4'h4;
  localparam offset_t OFS_8 = 4'h8;
  localparam offset_t OFS_C = 4'hC;

  localparam int unsigned GPIO_W = 16;
  typedef logic [GPIO_W-1:0] gpio_t;

  // Interrupt sources, ID 0 never fires
  localparam int unsigned NUM_EXT_INTR = 8;
  localparam int unsigned NUM_SRC      = 32;
  typedef logic [$clog2(NUM_SRC)-1:0] irq_id_t;

  localparam int unsigned ID_EXT_BASE  = 1;
  localparam int unsigned ID_GPIO_BASE = 9;
  localparam int unsigned ID_TIMER0    = 25;
  localparam int unsigned ID_TIMER1    = 26;

  typedef enum logic {IDLE, RESP} xbar_state_e;

endpackage

// File: hw/reg_bus_if.sv
////////////////////
// Register bus
// Decoder to peripheral, one word access per valid cycle
////////////////////

`timescale 1ns/1ps

interface reg_bus_if
  import periph_pkg::*;
();

  logic    valid;
  logic    write;
  offset_t addr;
  word_t   wdata;
  word_t   rdata;

  modport master (output valid, output write, output addr, output wdata, input rdata);

  modport slave (input valid, input write, input addr, input wdata, output rdata);

endinterface

// File: hw/periph_xbar.sv
////////////////////
// Register bus decoder
// Grants core requests and steers them to one peripheral
////////////////////

`timescale 1ns/1ps

module periph_xbar
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  obi_req_i,
  input  addr_t obi_addr_i,
  input  logic  obi_we_i,
  input  word_t obi_wdata_i,
  output logic  obi_gnt_o,
  output logic  obi_rvalid_o,
  output word_t obi_rdata_o,
  output logic  obi_err_o,
  reg_bus_if.master intr_bus,
  reg_bus_if.master gpio_bus,
  reg_bus_if.master timer_bus
);

  xbar_state_e state_q;
  region_t     region;
  offset_t     offset;
  logic        mapped;
  word_t       sel_rdata;

  assign region    = obi_addr_i[15:12];
  assign offset    = obi_addr_i[3:0];
  assign obi_gnt_o = obi_req_i && (state_q == IDLE);

  // Only the selected region sees valid
  assign intr_bus.valid  = obi_gnt_o && (region == REGION_INTR);
  assign gpio_bus.valid  = obi_gnt_o && (region == REGION_GPIO);
  assign timer_bus.valid = obi_gnt_o && (region == REGION_TIMER);

  assign intr_bus.write  = obi_we_i;
  assign gpio_bus.write  = obi_we_i;
  assign timer_bus.write = obi_we_i;
  assign intr_bus.addr   = offset;
  assign gpio_bus.addr   = offset;
  assign timer_bus.addr  = offset;
  assign intr_bus.wdata  = obi_wdata_i;
  assign gpio_bus.wdata  = obi_wdata_i;
  assign timer_bus.wdata = obi_wdata_i;

  always_comb begin
    mapped    = 1'b1;
    sel_rdata = '0;
    case (region)
      REGION_INTR:  sel_rdata = intr_bus.rdata;
      REGION_GPIO:  sel_rdata = gpio_bus.rdata;
      REGION_TIMER: sel_rdata = timer_bus.rdata;
      default:      mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= IDLE;
      obi_rvalid_o <= 1'b0;
      obi_err_o    <= 1'b0;
    end else begin
      state_q      <= obi_gnt_o ? RESP : IDLE;
      obi_rvalid_o <= obi_gnt_o;
      obi_err_o    <= obi_gnt_o && !mapped;
    end
  end

  // Writes and errors read back as zero
  always_ff @(posedge clk_i) begin
    if (obi_gnt_o) begin
      obi_rdata_o <= (mapped && !obi_we_i) ? sel_rdata : '0;
    end
  end

endmodule

// File: hw/intr_ctrl.sv
////////////////////
// Interrupt controller
// Edge capture, pending, enable, claim and software interrupt
////////////////////

`timescale 1ns/1ps

module intr_ctrl
  import periph_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  reg_bus_if.slave                bus,
  input  logic [NUM_EXT_INTR-1:0] ext_intr_i,
  input  gpio_t                   gpio_intr_i,
  input  logic [1:0]              timer_intr_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] src_q;
  logic [NUM_SRC-1:0] src_qq;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] pending_d;
  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] active;
  logic               msip_q;
  logic               claim_rd;
  irq_id_t            claim_id;

  // Source map, unused IDs stay zero
  always_comb begin
    src = '0;
    src[ID_EXT_BASE +: NUM_EXT_INTR] = ext_intr_i;
    src[ID_GPIO_BASE +: GPIO_W]      = gpio_intr_i;
    src[ID_TIMER0]                   = timer_intr_i[0];
    src[ID_TIMER1]                   = timer_intr_i[1];
  end

  assign active = pending_q & enable_q;

  // Lowest active ID wins
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = irq_id_t'(i);
      end
    end
  end

  assign claim_rd = bus.valid && !bus.write && (bus.addr == OFS_8);

  always_comb begin
    pending_d = pending_q;
    if (claim_rd && (claim_id != '0)) begin
      pending_d[claim_id] = 1'b0;
    end
    // New edges win over a claim in the same cycle
    pending_d = pending_d | (src_q & ~src_qq);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q     <= '0;
      src_qq    <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
    end else begin
      src_q     <= src;
      src_qq    <= src_q;
      pending_q <= pending_d;
      if (bus.valid && bus.write) begin
        case (bus.addr)
          OFS_4:   enable_q <= bus.wdata;
          OFS_C:   msip_q <= bus.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    if (bus.valid) begin
      case (bus.addr)
        OFS_0:   bus.rdata = pending_q;
        OFS_4:   bus.rdata = enable_q;
        OFS_8:   bus.rdata = word_t'(claim_id);
        OFS_C:   bus.rdata = word_t'(msip_q);
        default: bus.rdata = '0;
      endcase
    end
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

endmodule

// File: hw/gpio_port.sv
////////////////////
// GPIO block
// 16 pins with output, enable and rising-edge interrupts
////////////////////

`timescale 1ns/1ps

module gpio_port
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  reg_bus_if.slave bus,
  input  gpio_t    gpio_i,
  output gpio_t    gpio_o,
  output gpio_t    gpio_en_o,
  output gpio_t    gpio_intr_o
);

  gpio_t sync1_q;
  gpio_t sync2_q;
  gpio_t prev_q;
  gpio_t out_q;
  gpio_t oe_q;
  gpio_t intr_en_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q     <= '0;
      sync2_q     <= '0;
      prev_q      <= '0;
      out_q       <= '0;
      oe_q        <= '0;
      intr_en_q   <= '0;
      gpio_intr_o <= '0;
    end else begin
      // Two-flop synchronizer, then edge detect
      sync1_q     <= gpio_i;
      sync2_q     <= sync1_q;
      prev_q      <= sync2_q;
      gpio_intr_o <= sync2_q & ~prev_q & intr_en_q;
      if (bus.valid && bus.write) begin
        case (bus.addr)
          OFS_4:   out_q <= bus.wdata[GPIO_W-1:0];
          OFS_8:   oe_q <= bus.wdata[GPIO_W-1:0];
          OFS_C:   intr_en_q <= bus.wdata[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    if (bus.valid) begin
      case (bus.addr)
        OFS_0:   bus.rdata = word_t'(sync2_q);
        OFS_4:   bus.rdata = word_t'(out_q);
        OFS_8:   bus.rdata = word_t'(oe_q);
        OFS_C:   bus.rdata = word_t'(intr_en_q);
        default: bus.rdata = '0;
      endcase
    end
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;

endmodule

// File: hw/mtimer.sv
////////////////////
// Machine timer
// Free-running counter with two compare interrupts
////////////////////

`timescale 1ns/1ps

module mtimer
  import periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  reg_bus_if.slave   bus,
  output logic [1:0] timer_intr_o
);

  word_t mtime_q;
  word_t cmp_q [2];
  logic  en_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q      <= '0;
      cmp_q[0]     <= '1;
      cmp_q[1]     <= '1;
      en_q         <= 1'b0;
      timer_intr_o <= '0;
    end else begin
      // A write to MTIME overrides the increment
      if (bus.valid && bus.write && (bus.addr == OFS_0)) begin
        mtime_q <= bus.wdata;
      end else if (en_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (bus.valid && bus.write) begin
        case (bus.addr)
          OFS_4:   cmp_q[0] <= bus.wdata;
          OFS_8:   cmp_q[1] <= bus.wdata;
          OFS_C:   en_q <= bus.wdata[0];
          default: ;
        endcase
      end
      for (int i = 0; i < 2; i++) begin
        timer_intr_o[i] <= en_q && (mtime_q >= cmp_q[i]);
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    if (bus.valid) begin
      case (bus.addr)
        OFS_0:   bus.rdata = mtime_q;
        OFS_4:   bus.rdata = cmp_q[0];
        OFS_8:   bus.rdata = cmp_q[1];
        OFS_C:   bus.rdata = word_t'(en_q);
        default: bus.rdata = '0;
      endcase
    end
  end

endmodule

// File: hw/peripheral_subsystem.sv
////////////////////
// Peripheral subsystem top
// Bus decoder with interrupt controller, GPIO and timer
////////////////////

`timescale 1ns/1ps

module peripheral_subsystem
  import periph_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    obi_req_i,
  input  addr_t                   obi_addr_i,
  input  logic                    obi_we_i,
  input  word_t                   obi_wdata_i,
  output logic                    obi_gnt_o,
  output logic                    obi_rvalid_o,
  output word_t                   obi_rdata_o,
  output logic                    obi_err_o,
  input  logic [NUM_EXT_INTR-1:0] ext_intr_i,
  input  gpio_t                   gpio_i,
  output gpio_t                   gpio_o,
  output gpio_t                   gpio_en_o,
  output logic                    irq_o,
  output logic                    msip_o,
  output logic [1:0]              timer_intr_o
);

  gpio_t      gpio_intr;
  logic [1:0] timer_intr;

  reg_bus_if intr_bus ();
  reg_bus_if gpio_bus ();
  reg_bus_if timer_bus ();

  periph_xbar u_xbar (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .obi_req_i    (obi_req_i),
    .obi_addr_i   (obi_addr_i),
    .obi_we_i     (obi_we_i),
    .obi_wdata_i  (obi_wdata_i),
    .obi_gnt_o    (obi_gnt_o),
    .obi_rvalid_o (obi_rvalid_o),
    .obi_rdata_o  (obi_rdata_o),
    .obi_err_o    (obi_err_o),
    .intr_bus     (intr_bus),
    .gpio_bus     (gpio_bus),
    .timer_bus    (timer_bus)
  );

  intr_ctrl u_intr_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus          (intr_bus),
    .ext_intr_i   (ext_intr_i),
    .gpio_intr_i  (gpio_intr),
    .timer_intr_i (timer_intr),
    .irq_o        (irq_o),
    .msip_o       (msip_o)
  );

  gpio_port u_gpio (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus         (gpio_bus),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .gpio_intr_o (gpio_intr)
  );

  mtimer u_timer (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus          (timer_bus),
    .timer_intr_o (timer_intr)
  );

  // Timer interrupts also leave the subsystem directly
  assign timer_intr_o = timer_intr;

endmodule

// File: verif/peripheral_subsystem_props.sv
////////////////////
// Bus and interrupt assertions
////////////////////

`timescale 1ns/1ps

module peripheral_subsystem_props
  import periph_pkg::*;
(
  input logic               clk_i,
  input logic               reset_i,
  input logic               obi_gnt_o,
  input logic               obi_rvalid_o,
  input logic               irq_o,
  input logic [NUM_SRC-1:0] pending_i,
  input logic [NUM_SRC-1:0] enable_i,
  input irq_id_t            claim_id_i
);

  assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rvalid_o |-> $past(obi_gnt_o))
    else $error("rvalid without a grant in the previous cycle");

  assert property (@(posedge clk_i) disable iff (reset_i)
    obi_gnt_o |=> (obi_rvalid_o && !obi_gnt_o))
    else $error("grant not followed by a single response cycle");

  // The claimed ID must be a pending enabled source
  assert property (@(posedge clk_i) disable iff (reset_i)
    irq_o |-> ((claim_id_i != '0) && pending_i[claim_id_i] && enable_i[claim_id_i]))
    else $error("irq high without a pending enabled source");

endmodule

bind peripheral_subsystem peripheral_subsystem_props u_props (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .obi_gnt_o    (obi_gnt_o),
  .obi_rvalid_o (obi_rvalid_o),
  .irq_o        (irq_o),
  .pending_i    (u_intr_ctrl.pending_q),
  .enable_i     (u_intr_ctrl.enable_q),
  .claim_id_i   (u_intr_ctrl.claim_id)
);

// File: verif/tb_peripheral_subsystem.sv
////////////////////
// Peripheral subsystem testbench
// Table-driven bus accesses, pin stimulus and status waits
////////////////////

`timescale 1ns/1ps

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  localparam logic [1:0] OP_RD   = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_WAIT = 2'd2;
  localparam addr_t      GRP_PINS = 32'd0;
  localparam addr_t      GRP_IRQ  = 32'd1;
  localparam int         WAIT_MAX = 100;

  // For waits, addr picks the status group and wdata is the mask
  typedef struct packed {
    logic [1:0]  op;
    addr_t       addr;
    word_t       wdata;
    logic [23:0] pins;
    word_t       exp;
    logic        err;
  } row_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    obi_req_i;
  addr_t                   obi_addr_i;
  logic                    obi_we_i;
  word_t                   obi_wdata_i;
  logic                    obi_gnt_o;
  logic                    obi_rvalid_o;
  word_t                   obi_rdata_o;
  logic                    obi_err_o;
  logic [NUM_EXT_INTR-1:0] ext_intr_i;
  gpio_t                   gpio_i;
  gpio_t                   gpio_o;
  gpio_t                   gpio_en_o;
  logic                    irq_o;
  logic                    msip_o;
  logic [1:0]              timer_intr_o;

  row_t   rows[$];
  logic   rows_ready;
  integer seed;

  peripheral_subsystem u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic addr_t addr_of(input region_t region, input offset_t ofs);
    return {16'h0000, region, 8'h00, ofs};
  endfunction

  function automatic word_t status_of(input addr_t grp);
    if (grp == GRP_PINS) begin
      return {gpio_en_o, gpio_o};
    end
    return {28'h0, timer_intr_o, msip_o, irq_o};
  endfunction

  task automatic add_row(input logic [1:0] op, input addr_t addr, input word_t wdata,
                         input logic [23:0] pins, input word_t exp, input logic err);
    row_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.pins  = pins;
    r.exp   = exp;
    r.err   = err;
    rows.push_back(r);
  endtask

  task automatic build_rows();
    gpio_t       in_val;
    gpio_t       out_val;
    gpio_t       oe_val;
    int          k;
    logic [23:0] pin_k;
    in_val  = gpio_t'($random(seed));
    out_val = gpio_t'($random(seed));
    oe_val  = gpio_t'($random(seed));
    k       = $random(seed) & 15;
    pin_k   = 24'(1) << k;
    // GPIO output, enable and input readback
    add_row(OP_WR, addr_of(REGION_GPIO, OFS_4), out_val, {8'h00, in_val}, 0, 0);
    add_row(OP_WR, addr_of(REGION_GPIO, OFS_8), oe_val, {8'h00, in_val}, 0, 0);
    add_row(OP_RD, addr_of(REGION_GPIO, OFS_0), 0, {8'h00, in_val}, in_val, 0);
    add_row(OP_RD, addr_of(REGION_GPIO, OFS_4), 0, {8'h00, in_val}, out_val, 0);
    add_row(OP_RD, addr_of(REGION_GPIO, OFS_8), 0, {8'h00, in_val}, oe_val, 0);
    add_row(OP_WAIT, GRP_PINS, 32'hFFFF_FFFF, {8'h00, in_val}, {oe_val, out_val}, 0);
    // GPIO interrupt on pin k
    add_row(OP_WR, addr_of(REGION_GPIO, OFS_C), word_t'(1) << k, 0, 0, 0);
    add_row(OP_WR, addr_of(REGION_INTR, OFS_4), word_t'(1) << (ID_GPIO_BASE + k), 0, 0, 0);
    add_row(OP_WAIT, GRP_IRQ, 32'h1, pin_k, 32'h1, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_8), 0, pin_k, ID_GPIO_BASE + k, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_8), 0, pin_k, 0, 0);
    add_row(OP_WAIT, GRP_IRQ, 32'h1, pin_k, 32'h0, 0);
    // External bits 5 and 2 are IDs 6 and 3
    add_row(OP_WR, addr_of(REGION_INTR, OFS_4), 32'h0000_01FE, pin_k | 24'h24_0000, 0, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_0), 0, pin_k, 32'h48, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_8), 0, pin_k, 3, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_0), 0, pin_k, 32'h40, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_8), 0, pin_k, 6, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_0), 0, pin_k, 0, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_8), 0, pin_k, 0, 0);
    // Timer compare 0 through the interrupt controller
    add_row(OP_WR, addr_of(REGION_INTR, OFS_4), word_t'(1) << ID_TIMER0, pin_k, 0, 0);
    add_row(OP_WR, addr_of(REGION_TIMER, OFS_4), 40, pin_k, 0, 0);
    add_row(OP_WR, addr_of(REGION_TIMER, OFS_0), 0, pin_k, 0, 0);
    add_row(OP_WR, addr_of(REGION_TIMER, OFS_C), 1, pin_k, 0, 0);
    add_row(OP_WAIT, GRP_IRQ, 32'h5, pin_k, 32'h5, 0);
    add_row(OP_RD, addr_of(REGION_INTR, OFS_8), 0, pin_k, ID_TIMER0, 0);
    add_row(OP_WAIT, GRP_IRQ, 32'h9, pin_k, 32'h0, 0);
    add_row(OP_RD, addr_of(REGION_TIMER, OFS_8), 0, pin_k, 32'hFFFF_FFFF, 0);
    // Software interrupt, then unmapped region 5
    add_row(OP_WR, addr_of(REGION_INTR, OFS_C), 1, pin_k, 0, 0);
    add_row(OP_WAIT, GRP_IRQ, 32'h2, pin_k, 32'h2, 0);
    add_row(OP_WR, addr_of(REGION_INTR, OFS_C), 0, pin_k, 0, 0);
    add_row(OP_WAIT, GRP_IRQ, 32'h2, pin_k, 32'h0, 0);
    add_row(OP_RD, addr_of(4'h5, OFS_0), 0, pin_k, 0, 1);
    add_row(OP_WR, addr_of(4'h5, OFS_4), 32'hDEAD_BEEF, pin_k, 0, 1);
    add_row(OP_RD, addr_of(REGION_GPIO, OFS_4), 0, pin_k, out_val, 0);
    add_row(OP_RD, addr_of(REGION_TIMER, OFS_4), 0, pin_k, 40, 0);
  endtask

  // Starts right after a rising edge and returns on one
  task automatic bus_access(input logic we, input addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
    obi_req_i   <= 1'b1;
    obi_we_i    <= we;
    obi_addr_i  <= addr;
    obi_wdata_i <= wdata;
    @(negedge clk_i);
    while (!obi_gnt_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    obi_req_i <= 1'b0;
    @(negedge clk_i);
    while (!obi_rvalid_o) begin
      @(negedge clk_i);
    end
    rdata = obi_rdata_o;
    err   = obi_err_o;
    @(posedge clk_i);
  endtask

  task automatic wait_status(input addr_t grp, input word_t mask, input word_t exp);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (((status_of(grp) & mask) != exp) && (cycles < WAIT_MAX)) begin
      @(negedge clk_i);
      cycles++;
    end
    check_value("status after bounded wait", status_of(grp) & mask, exp);
    @(posedge clk_i);
  endtask

  initial begin
    wait (rows_ready);
    repeat (rows.size() * 50 + 500) @(posedge clk_i);
    fail_run("Watchdog expired before the test table finished");
  end

  initial begin
    row_t  r;
    word_t rdata;
    logic  err;
    seed        = 32'h2de0c121;
    reset_i     = 1'b1;
    obi_req_i   = 1'b0;
    obi_addr_i  = '0;
    obi_we_i    = 1'b0;
    obi_wdata_i = '0;
    ext_intr_i  = '0;
    gpio_i      = '0;
    build_rows();
    rows_ready = 1'b1;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    foreach (rows[i]) begin
      r = rows[i];
      gpio_i     <= r.pins[15:0];
      ext_intr_i <= r.pins[23:16];
      if (r.op == OP_WAIT) begin
        wait_status(r.addr, r.wdata, r.exp);
      end else begin
        bus_access(r.op == OP_WR, r.addr, r.wdata, rdata, err);
        check_value($sformatf("row %0d read data", i), rdata, r.exp);
        check_value($sformatf("row %0d error flag", i), word_t'(err), word_t'(r.err));
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: peripheral_subsystem.f
hw/periph_pkg.sv
hw/reg_bus_if.sv
hw/periph_xbar.sv
hw/intr_ctrl.sv
hw/gpio_port.sv
hw/mtimer.sv
hw/peripheral_subsystem.sv
verif/peripheral_subsystem_props.sv
verif/tb_peripheral_subsystem.sv

// File: Bender.yml
package:
  name: peripheral_subsystem

sources:
  - files:
      - hw/periph_pkg.sv
      - hw/reg_bus_if.sv
      - hw/periph_xbar.sv
      - hw/intr_ctrl.sv
      - hw/gpio_port.sv
      - hw/mtimer.sv
      - hw/peripheral_subsystem.sv
  - target: test
    files:
      - verif/peripheral_subsystem_props.sv
      - verif/tb_peripheral_subsystem.sv
